// File: common/robot_params.svh
`ifndef ROBOT_PARAMS_SVH
`define ROBOT_PARAMS_SVH

// Counter widths
`define SETTLE_W 25
`define INTERSECT_W 28

// Limits after reset, in clock cycles
`define SETTLE_DEFAULT 500000
`define INTERSECT_DEFAULT 20000000

// PWM timing and duty levels, in cycles per period
`define PWM_PERIOD 16
`define DUTY_FULL 16
`define DUTY_VEER 12
`define DUTY_HARD 4
`define DUTY_NINETY 8

`endif

// File: common/robotSensePkg.sv
`default_nettype none

package robotSensePkg;

	// One sensor pair, 1 means over the line
	typedef struct packed {
		logic right;
		logic left;
	} sensePair;

	typedef enum logic {
		BACKWARDS = 1'b0,
		FORWARDS  = 1'b1
	} travelDir;

	// Direction controller FSM
	typedef enum logic [1:0] {
		NORMAL        = 2'b00,
		DEBOUNCE      = 2'b01, // Waiting for the pattern to settle
		CHANGE_DIR    = 2'b10,
		CHK_INTERSECT = 2'b11  // Front pair lost, look at middle pair
	} ctrlState;

endpackage

`default_nettype wire

// File: common/robotDrivePkg.sv
`default_nettype none

package robotDrivePkg;

	// Upper two bits give the side, lower two the strength
	typedef enum logic [3:0] {
		PROCEED      = 4'b00_00,
		VEER_RIGHT   = 4'b10_01,
		HARD_RIGHT   = 4'b10_10,
		NINETY_RIGHT = 4'b10_11,
		VEER_LEFT    = 4'b01_01,
		HARD_LEFT    = 4'b01_10,
		NINETY_LEFT  = 4'b01_11,
		STOP         = 4'b11_11
	} steerCmd;

	// Configuration register select
	typedef enum logic {
		SETTLE_LIMIT    = 1'b0,
		INTERSECT_LIMIT = 1'b1
	} cfgAddr;

	// Per-wheel drive setting, latched once per PWM period
	typedef struct packed {
		logic [7:0] duty;    // High cycles per period
		logic       reverse; // Wheel spins backwards
	} wheelDrive;

endpackage

`default_nettype wire

// File: common/senseIf.sv
`default_nettype none

// Cleaned sensor pairs and travel direction
interface senseIf;

	robotSensePkg::sensePair front;
	robotSensePkg::sensePair middle;
	robotSensePkg::sensePair rear;
	robotSensePkg::travelDir dir;

	modport source (
		output front,
		output middle,
		output rear,
		output dir
	);

	modport sink (
		input front,
		input middle,
		input rear,
		input dir
	);

endinterface

`default_nettype wire

// File: hw/sensorFrontEnd.sv
`default_nettype none

module sensorFrontEnd (
	input wire logic clk,
	input wire logic reset,
	input wire logic rfs,
	input wire logic rrs,
	input wire logic rms,
	input wire logic lms,
	input wire logic lfs,
	input wire logic lrs,
	input wire logic direction,
	senseIf.source sense
);

	// Bit order per stage: front r/l, middle r/l, rear r/l, direction
	logic [6:0] rawBits;
	logic [2:0][6:0] syncChain;

	// Sensors pull low over the line
	assign rawBits = {~{rfs, lfs, rms, lms, rrs, lrs}, direction};

	////////////////////////////////////////////////////////////////////////////
	// Three-stage synchronizer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			syncChain <= '0;
		end else begin
			syncChain <= {syncChain[1:0], rawBits}; // Stage 0 takes the raw pins
		end
	end

	assign sense.front  = robotSensePkg::sensePair'(syncChain[2][6:5]);
	assign sense.middle = robotSensePkg::sensePair'(syncChain[2][4:3]);
	assign sense.rear   = robotSensePkg::sensePair'(syncChain[2][2:1]);
	assign sense.dir    = robotSensePkg::travelDir'(syncChain[2][0]);

endmodule

`default_nettype wire

// File: steering/steerConfig.sv
`default_nettype none

`include "robot_params.svh"

module steerConfig (
	input wire logic clk,
	input wire logic reset,
	input wire logic cfgWrite,
	input wire robotDrivePkg::cfgAddr cfgSel,
	input wire logic [`INTERSECT_W-1:0] cfgData,
	output logic [`SETTLE_W-1:0] settleLimit,
	output logic [`INTERSECT_W-1:0] intersectLimit
);

	logic [`SETTLE_W-1:0] settleData;

	assign settleData = cfgData[`SETTLE_W-1:0]; // Settle limit is the narrower one

	always_ff @(posedge clk) begin
		if (reset) begin
			settleLimit    <= `SETTLE_W'(`SETTLE_DEFAULT);
			intersectLimit <= `INTERSECT_W'(`INTERSECT_DEFAULT);
		end else if (cfgWrite) begin
			case (cfgSel)
				robotDrivePkg::SETTLE_LIMIT: begin
					if (settleData != '0)
						settleLimit <= settleData;
				end
				robotDrivePkg::INTERSECT_LIMIT: begin
					if (cfgData != '0)
						intersectLimit <= cfgData;
				end
				default: ;
			endcase
		end
	end

	// A zero limit would stall the controller counters
	limitsNonZero: assert property (
		@(posedge clk) disable iff (reset)
		settleLimit != '0 && intersectLimit != '0
	);

endmodule

`default_nettype wire

// File: steering/directionControl.sv
`default_nettype none

`include "robot_params.svh"

module directionControl (
	input wire logic clk,
	input wire logic reset,
	senseIf.sink sense,
	input wire logic [`SETTLE_W-1:0] settleLimit,
	input wire logic [`INTERSECT_W-1:0] intersectLimit,
	output robotDrivePkg::steerCmd steer
);

	robotSensePkg::ctrlState state;
	robotSensePkg::travelDir lastDir; // Direction last acted on

	logic [5:0] pattern;     // Front, middle, rear pairs
	logic [5:0] prevPattern;
	logic [5:0] snapshot;    // Pattern before the change
	logic [`SETTLE_W-1:0] settleCount;
	logic [`INTERSECT_W-1:0] intersectCount;

	assign pattern = {sense.front, sense.middle, sense.rear};

	// Held while idle, frozen once DEBOUNCE starts
	always_ff @(posedge clk) begin
		if (state == robotSensePkg::NORMAL)
			snapshot <= prevPattern;
	end

	////////////////////////////////////////////////////////////////////////////
	// Steering FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state          <= robotSensePkg::NORMAL;
			steer          <= robotDrivePkg::STOP;
			lastDir        <= robotSensePkg::BACKWARDS;
			prevPattern    <= '0;
			settleCount    <= '0;
			intersectCount <= '0;
		end else begin
			prevPattern <= pattern;

			case (state)
				robotSensePkg::NORMAL: begin
					if (pattern != prevPattern || sense.dir != lastDir) begin
						state       <= robotSensePkg::DEBOUNCE;
						settleCount <= '0;
					end
				end

				robotSensePkg::DEBOUNCE: begin
					if (pattern == snapshot && sense.dir == lastDir)
						state <= robotSensePkg::NORMAL; // Glitch, keep steer
					else if (settleCount >= settleLimit - 1'b1)
						state <= robotSensePkg::CHANGE_DIR;
					else
						settleCount <= settleCount + 1'b1;
				end

				robotSensePkg::CHANGE_DIR: begin
					lastDir        <= sense.dir;
					intersectCount <= '0;
					state          <= robotSensePkg::NORMAL;
					if (sense.dir == robotSensePkg::FORWARDS) begin
						case (sense.front)
							2'b11: steer <= robotDrivePkg::PROCEED;
							2'b10: steer <= robotDrivePkg::HARD_RIGHT;
							2'b01: steer <= robotDrivePkg::HARD_LEFT;
							default: state <= robotSensePkg::CHK_INTERSECT;
						endcase
					end else begin
						// Backwards only veers
						case (sense.rear)
							2'b11: steer <= robotDrivePkg::PROCEED;
							2'b01: steer <= robotDrivePkg::VEER_LEFT;
							2'b10: steer <= robotDrivePkg::VEER_RIGHT;
							default: state <= robotSensePkg::CHK_INTERSECT;
						endcase
					end
				end

				robotSensePkg::CHK_INTERSECT: begin
					if (sense.middle == 2'b11 || intersectCount >= intersectLimit) begin
						steer <= robotDrivePkg::STOP; // Crossing or line end
						state <= robotSensePkg::NORMAL;
					end else if (sense.front != 2'b00) begin
						state <= robotSensePkg::CHANGE_DIR;
					end else begin
						case (sense.middle)
							2'b01: steer <= robotDrivePkg::NINETY_LEFT;
							2'b10: steer <= robotDrivePkg::NINETY_RIGHT;
							default: begin
								steer          <= robotDrivePkg::PROCEED;
								intersectCount <= intersectCount + 1'b1;
							end
						endcase
					end
				end

				default: state <= robotSensePkg::NORMAL;
			endcase
		end
	end

	// Assertions

	steerKnown: assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(steer)
	);

	// Count restarts on entry, so this bounds the DEBOUNCE length
	debounceBounded: assert property (
		@(posedge clk) disable iff (reset)
		state == robotSensePkg::DEBOUNCE |-> settleCount < settleLimit
	);

endmodule

`default_nettype wire

// File: hw/motorDrive.sv
`default_nettype none

`include "robot_params.svh"

module motorDrive (
	input wire logic clk,
	input wire logic reset,
	input wire robotDrivePkg::steerCmd steer,
	output logic leftPwm,
	output logic rightPwm,
	output logic leftReverse,
	output logic rightReverse
);

	localparam int CntW = $clog2(`PWM_PERIOD);

	logic [CntW-1:0] pwmCount;
	logic periodEnd;
	robotDrivePkg::wheelDrive leftDrive, rightDrive;
	robotDrivePkg::wheelDrive nextLeft, nextRight;

	assign periodEnd = (pwmCount == CntW'(`PWM_PERIOD - 1));

	////////////////////////////////////////////////////////////////////////////
	// Command decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		nextLeft  = '{duty: 8'(`DUTY_FULL), reverse: 1'b0};
		nextRight = '{duty: 8'(`DUTY_FULL), reverse: 1'b0};
		case (steer)
			robotDrivePkg::PROCEED: ;
			robotDrivePkg::VEER_RIGHT: nextRight.duty = 8'(`DUTY_VEER);
			robotDrivePkg::HARD_RIGHT: nextRight.duty = 8'(`DUTY_HARD);
			robotDrivePkg::VEER_LEFT:  nextLeft.duty  = 8'(`DUTY_VEER);
			robotDrivePkg::HARD_LEFT:  nextLeft.duty  = 8'(`DUTY_HARD);
			robotDrivePkg::NINETY_RIGHT: begin
				nextLeft  = '{duty: 8'(`DUTY_NINETY), reverse: 1'b0};
				nextRight = '{duty: 8'(`DUTY_NINETY), reverse: 1'b1}; // Pivot right
			end
			robotDrivePkg::NINETY_LEFT: begin
				nextLeft  = '{duty: 8'(`DUTY_NINETY), reverse: 1'b1};
				nextRight = '{duty: 8'(`DUTY_NINETY), reverse: 1'b0};
			end
			default: begin // STOP
				nextLeft  = '0;
				nextRight = '0;
			end
		endcase
	end

	// Period counter, drive latched only at the wrap
	always_ff @(posedge clk) begin
		if (reset) begin
			pwmCount   <= '0;
			leftDrive  <= '0;
			rightDrive <= '0;
		end else begin
			pwmCount <= periodEnd ? '0 : pwmCount + 1'b1;
			if (periodEnd) begin
				leftDrive  <= nextLeft;
				rightDrive <= nextRight;
			end
		end
	end

	// High for the first duty cycles of the period
	assign leftPwm      = (8'(pwmCount) < leftDrive.duty);
	assign rightPwm     = (8'(pwmCount) < rightDrive.duty);
	assign leftReverse  = leftDrive.reverse;
	assign rightReverse = rightDrive.reverse;

	dutyInRange: assert property (
		@(posedge clk) disable iff (reset)
		leftDrive.duty <= 8'(`PWM_PERIOD) && rightDrive.duty <= 8'(`PWM_PERIOD)
	);

endmodule

`default_nettype wire

// File: hw/lineFollowerTop.sv
`default_nettype none

`include "robot_params.svh"

module lineFollowerTop (
	input wire logic clk,
	input wire logic reset,
	input wire logic rfs,
	input wire logic rrs,
	input wire logic rms,
	input wire logic lms,
	input wire logic lfs,
	input wire logic lrs,
	input wire logic direction,
	input wire logic cfgWrite,
	input wire robotDrivePkg::cfgAddr cfgSel,
	input wire logic [`INTERSECT_W-1:0] cfgData,
	output robotDrivePkg::steerCmd steer,
	output logic leftPwm,
	output logic rightPwm,
	output logic leftReverse,
	output logic rightReverse
);

	logic [`SETTLE_W-1:0] settleLimit;
	logic [`INTERSECT_W-1:0] intersectLimit;

	senseIf sense ();

	sensorFrontEnd frontEnd (
		.clk(clk),
		.reset(reset),
		.rfs(rfs),
		.rrs(rrs),
		.rms(rms),
		.lms(lms),
		.lfs(lfs),
		.lrs(lrs),
		.direction(direction),
		.sense(sense.source)
	);

	steerConfig config0 (
		.clk(clk),
		.reset(reset),
		.cfgWrite(cfgWrite),
		.cfgSel(cfgSel),
		.cfgData(cfgData),
		.settleLimit(settleLimit),
		.intersectLimit(intersectLimit)
	);

	directionControl dirCtrl (
		.clk(clk),
		.reset(reset),
		.sense(sense.sink),
		.settleLimit(settleLimit),
		.intersectLimit(intersectLimit),
		.steer(steer)
	);

	motorDrive motors (
		.clk(clk),
		.reset(reset),
		.steer(steer),
		.leftPwm(leftPwm),
		.rightPwm(rightPwm),
		.leftReverse(leftReverse),
		.rightReverse(rightReverse)
	);

endmodule

`default_nettype wire

// File: dv/tbLineFollower.sv
`default_nettype none

`include "robot_params.svh"

module tbLineFollower;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int SettleTest    = 20;
	localparam int IntersectTest = 200;
	localparam int HoldCycles    = SettleTest + 10; // Steady time before steer is read
	localparam int MaxCycles     = 20000;

	logic clk;
	logic reset;
	logic rfs, rrs, rms, lms, lfs, lrs;
	logic direction;
	logic cfgWrite;
	robotDrivePkg::cfgAddr cfgSel;
	logic [`INTERSECT_W-1:0] cfgData;
	robotDrivePkg::steerCmd steer;
	logic leftPwm, rightPwm, leftReverse, rightReverse;

	int steerErrors = 0;
	int driveErrors = 0;
	int stateErrors = 0;
	int cycleCount  = 0;
	logic [15:0] lfsrState = 16'd43;
	logic [5:0] pinPattern = '0; // Front, middle, rear pairs, 1 over the line

	lineFollowerTop UUT (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= MaxCycles) begin
			$display("Timeout: test sequence still running after %0d cycles", cycleCount);
			$display("Simulation failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// Taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] galoisStep(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
	endfunction

	task automatic takeBits(input int count, output logic [15:0] bits);
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits[i]   = lfsrState[0];
			lfsrState = galoisStep(lfsrState);
		end
	endtask

	task automatic drivePins(input robotSensePkg::travelDir dir, input logic [5:0] pattern);
		@(posedge clk);
		direction <= dir;
		{rfs, lfs, rms, lms, rrs, lrs} <= ~pattern; // Pins pull low over the line
		pinPattern = pattern;
	endtask

	task automatic writeConfig(input robotDrivePkg::cfgAddr sel,
		input logic [`INTERSECT_W-1:0] data);
		@(posedge clk);
		cfgWrite <= 1'b1;
		cfgSel   <= sel;
		cfgData  <= data;
		@(posedge clk);
		cfgWrite <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// Left duty, right duty, left reverse, right reverse
	function automatic logic [17:0] driveTable(input robotDrivePkg::steerCmd cmd);
		case (cmd)
			robotDrivePkg::PROCEED:      return {8'(`DUTY_FULL), 8'(`DUTY_FULL), 2'b00};
			robotDrivePkg::VEER_RIGHT:   return {8'(`DUTY_FULL), 8'(`DUTY_VEER), 2'b00};
			robotDrivePkg::HARD_RIGHT:   return {8'(`DUTY_FULL), 8'(`DUTY_HARD), 2'b00};
			robotDrivePkg::NINETY_RIGHT: return {8'(`DUTY_NINETY), 8'(`DUTY_NINETY), 2'b01};
			robotDrivePkg::VEER_LEFT:    return {8'(`DUTY_VEER), 8'(`DUTY_FULL), 2'b00};
			robotDrivePkg::HARD_LEFT:    return {8'(`DUTY_HARD), 8'(`DUTY_FULL), 2'b00};
			robotDrivePkg::NINETY_LEFT:  return {8'(`DUTY_NINETY), 8'(`DUTY_NINETY), 2'b10};
			default:                     return 18'h0; // STOP
		endcase
	endfunction

	task automatic checkSteer(input robotDrivePkg::steerCmd expected);
		@(negedge clk);
		steerOk: assert (steer == expected) else begin
			steerErrors++;
			$display("Mismatch steer: expected 0x%h, actual 0x%h", expected, steer);
		end
	endtask

	task automatic checkIdle();
		checkSteer(robotDrivePkg::STOP);
		wheelsLow: assert ({leftPwm, rightPwm, leftReverse, rightReverse} == 4'b0) else begin
			driveErrors++;
			$display("Mismatch wheel outputs: expected 0x0, actual 0x%h",
				{leftPwm, rightPwm, leftReverse, rightReverse});
		end
	endtask

	// Any full period counts once the drive is constant
	task automatic checkDrive(input robotDrivePkg::steerCmd cmd);
		logic [17:0] expected;
		logic [7:0] leftHigh;
		logic [7:0] rightHigh;
		expected  = driveTable(cmd);
		leftHigh  = '0;
		rightHigh = '0;
		repeat (2 * `PWM_PERIOD) @(negedge clk);
		repeat (`PWM_PERIOD) begin
			@(negedge clk);
			leftHigh  = leftHigh + 8'(leftPwm);
			rightHigh = rightHigh + 8'(rightPwm);
		end
		leftDutyOk: assert (leftHigh == expected[17:10]) else begin
			driveErrors++;
			$display("Mismatch leftPwm high cycles: expected 0x%h, actual 0x%h",
				expected[17:10], leftHigh);
		end
		rightDutyOk: assert (rightHigh == expected[9:2]) else begin
			driveErrors++;
			$display("Mismatch rightPwm high cycles: expected 0x%h, actual 0x%h",
				expected[9:2], rightHigh);
		end
		reverseOk: assert ({leftReverse, rightReverse} == expected[1:0]) else begin
			driveErrors++;
			$display("Mismatch leftReverse,rightReverse: expected 0x%h, actual 0x%h",
				expected[1:0], {leftReverse, rightReverse});
		end
	endtask

	task automatic expectCommand(input robotDrivePkg::steerCmd cmd);
		repeat (HoldCycles) @(posedge clk);
		checkSteer(cmd);
		checkDrive(cmd);
	endtask

	// One cycle of steer and controller state while a glitch is filtered
	task automatic confirmFiltered(input robotDrivePkg::steerCmd held, input int glitchLen);
		checkSteer(held);
		noChange: assert (UUT.dirCtrl.state != robotSensePkg::CHANGE_DIR) else begin
			stateErrors++;
			$display("Glitch of %0d cycles reached CHANGE_DIR", glitchLen);
		end
	endtask

	// Short random glitch, then back to the steady pattern
	task automatic runGlitch(input robotDrivePkg::steerCmd held);
		logic [15:0] bits;
		logic [5:0] steady;
		logic [5:0] glitch;
		int glitchLen;
		steady = pinPattern;
		takeBits(6, bits);
		glitch = (bits[5:0] == 6'b0) ? steady ^ 6'b000001 : steady ^ bits[5:0];
		takeBits(4, bits);
		glitchLen = int'(bits[3:0]) + 1; // 1 to 16 cycles
		drivePins(robotSensePkg::FORWARDS, glitch);
		repeat (glitchLen) confirmFiltered(held, glitchLen);
		drivePins(robotSensePkg::FORWARDS, steady);
		repeat (HoldCycles) confirmFiltered(held, glitchLen);
		backToNormal: assert (UUT.dirCtrl.state == robotSensePkg::NORMAL) else begin
			stateErrors++;
			$display("Mismatch UUT.dirCtrl.state: expected 0x%h, actual 0x%h",
				robotSensePkg::NORMAL, UUT.dirCtrl.state);
		end
	endtask

	initial begin
		reset     = 1'b1;
		direction = 1'b0;
		{rfs, rrs, rms, lms, lfs, lrs} = '1; // All sensors off the line
		cfgWrite  = 1'b0;
		cfgSel    = robotDrivePkg::SETTLE_LIMIT;
		cfgData   = '0;

		repeat (2) checkIdle();
		@(posedge clk);
		reset <= 1'b0;
		repeat (2 * `PWM_PERIOD) checkIdle();

		writeConfig(robotDrivePkg::SETTLE_LIMIT, `INTERSECT_W'(SettleTest));
		writeConfig(robotDrivePkg::INTERSECT_LIMIT, `INTERSECT_W'(IntersectTest));

		// Forwards on the front pair
		drivePins(robotSensePkg::FORWARDS, 6'b11_00_00);
		expectCommand(robotDrivePkg::PROCEED);
		drivePins(robotSensePkg::FORWARDS, 6'b10_00_00);
		expectCommand(robotDrivePkg::HARD_RIGHT);
		drivePins(robotSensePkg::FORWARDS, 6'b01_00_00);
		expectCommand(robotDrivePkg::HARD_LEFT);

		repeat (4) runGlitch(robotDrivePkg::HARD_LEFT);

		// Front pair lost, middle pair decides
		drivePins(robotSensePkg::FORWARDS, 6'b00_01_00);
		expectCommand(robotDrivePkg::NINETY_LEFT);
		drivePins(robotSensePkg::FORWARDS, 6'b00_10_00);
		expectCommand(robotDrivePkg::NINETY_RIGHT);
		drivePins(robotSensePkg::FORWARDS, 6'b00_11_00);
		expectCommand(robotDrivePkg::STOP);
		drivePins(robotSensePkg::FORWARDS, 6'b00_00_00);
		expectCommand(robotDrivePkg::PROCEED);
		repeat (IntersectTest) @(posedge clk); // Intersection counter runs out
		checkSteer(robotDrivePkg::STOP);
		checkDrive(robotDrivePkg::STOP);

		// Backwards on the rear pair
		drivePins(robotSensePkg::BACKWARDS, 6'b00_00_11);
		expectCommand(robotDrivePkg::PROCEED);
		drivePins(robotSensePkg::BACKWARDS, 6'b00_00_01);
		expectCommand(robotDrivePkg::VEER_LEFT);
		drivePins(robotSensePkg::BACKWARDS, 6'b00_00_10);
		expectCommand(robotDrivePkg::VEER_RIGHT);

		$display("Errors: steer %0d, wheel drive %0d, controller state %0d",
			steerErrors, driveErrors, stateErrors);
		if (steerErrors + driveErrors + stateErrors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+common
common/robotSensePkg.sv
common/robotDrivePkg.sv
common/senseIf.sv
hw/sensorFrontEnd.sv
steering/steerConfig.sv
steering/directionControl.sv
hw/motorDrive.sv
hw/lineFollowerTop.sv
dv/tbLineFollower.sv

// File: Makefile
SOURCES := $(shell grep -v '^+' project.f) common/robot_params.svh

.PHONY: run clean

run: obj_dir/VtbLineFollower
	./obj_dir/VtbLineFollower > sim.log 2>&1; cat sim.log
	@if grep -q "Simulation failed" sim.log || ! grep -q "Simulation passed" sim.log; then \
		echo "Run failed, see sim.log"; exit 1; fi

obj_dir/VtbLineFollower: project.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tbLineFollower

clean:
	rm -rf obj_dir sim.log
